/* hw/decode_stage.sv */
`default_nettype none

module decode_stage (
        input wire clk,
        input wire rst_n,
        input wire freeze_i,
        input wire hold_i,
        input wire bubble_i,
        input wire mips_pkg::if_id_t if_id_i,
        input wire mips_pkg::word_t rs_data_i,
        input wire mips_pkg::word_t rt_data_i,
        output mips_pkg::reg_idx_t rs_o,
        output mips_pkg::reg_idx_t rt_o,
        input wire mips_pkg::fwd_t ex_fwd_i,
        input wire mips_pkg::fwd_t mm_fwd_i,
        input wire mips_pkg::wb_t wb_i,
        output logic redirect_o,
        output mips_pkg::word_t target_o,
        output mips_pkg::id_ex_t id_ex_o
);
        mips_pkg::word_t instr;
        mips_pkg::opcode_e opcode;
        mips_pkg::word_t imm_sext;
        mips_pkg::word_t imm_zext;
        mips_pkg::word_t rs_val;
        mips_pkg::word_t rt_val;
        mips_pkg::id_ex_t id_ex_d;
        logic is_beq;
        logic is_bne;

        // youngest producer wins, r0 never forwarded
        function automatic mips_pkg::word_t pick_operand(
                input mips_pkg::reg_idx_t idx,
                input mips_pkg::word_t rf_val,
                input mips_pkg::fwd_t ex,
                input mips_pkg::fwd_t mm,
                input mips_pkg::wb_t wb
        );
                mips_pkg::word_t val;
                val = rf_val;
                if (idx != '0) begin
                        if (ex.wr && ex.dst == idx) begin
                                val = ex.data;
                        end else if (mm.wr && mm.dst == idx) begin
                                val = mm.data;
                        end else if (wb.we && wb.idx == idx) begin
                                val = wb.data;
                        end
                end
                return val;
        endfunction

        assign instr = if_id_i.instr;
        assign opcode = mips_pkg::opcode_e'(instr[31:26]);
        assign rs_o = instr[25:21];
        assign rt_o = instr[20:16];
        assign imm_sext = {{16{instr[15]}}, instr[15:0]};
        assign imm_zext = {16'b0, instr[15:0]};
        assign rs_val = pick_operand(rs_o, rs_data_i, ex_fwd_i, mm_fwd_i, wb_i);
        assign rt_val = pick_operand(rt_o, rt_data_i, ex_fwd_i, mm_fwd_i, wb_i);

        always_comb begin
                id_ex_d = '0;
                is_beq = 1'b0;
                is_bne = 1'b0;
                id_ex_d.a = rs_val;
                id_ex_d.b = imm_sext;
                id_ex_d.dst = rt_o;
                case (opcode)
                        mips_pkg::OP_SPECIAL: begin
                                id_ex_d.b = rt_val;
                                id_ex_d.dst = instr[15:11];
                                id_ex_d.reg_wr = 1'b1;
                                case (mips_pkg::funct_e'(instr[5:0]))
                                        mips_pkg::FN_ADDU: id_ex_d.op = mips_pkg::ALU_ADD;
                                        mips_pkg::FN_SUBU: id_ex_d.op = mips_pkg::ALU_SUB;
                                        mips_pkg::FN_AND: id_ex_d.op = mips_pkg::ALU_AND;
                                        mips_pkg::FN_OR: id_ex_d.op = mips_pkg::ALU_OR;
                                        mips_pkg::FN_SLT: id_ex_d.op = mips_pkg::ALU_SLT;
                                        default: id_ex_d.reg_wr = 1'b0; // sll and friends act as nop
                                endcase
                        end
                        mips_pkg::OP_ADDIU: begin
                                id_ex_d.op = mips_pkg::ALU_ADD;
                                id_ex_d.reg_wr = 1'b1;
                        end
                        mips_pkg::OP_ORI: begin
                                id_ex_d.op = mips_pkg::ALU_OR;
                                id_ex_d.b = imm_zext;
                                id_ex_d.reg_wr = 1'b1;
                        end
                        mips_pkg::OP_LUI: begin
                                id_ex_d.op = mips_pkg::ALU_LUI;
                                id_ex_d.b = imm_zext;
                                id_ex_d.reg_wr = 1'b1;
                        end
                        mips_pkg::OP_LW: begin
                                id_ex_d.op = mips_pkg::ALU_ADD;
                                id_ex_d.reg_wr = 1'b1;
                                id_ex_d.load = 1'b1;
                        end
                        mips_pkg::OP_SW: begin
                                id_ex_d.op = mips_pkg::ALU_ADD;
                                id_ex_d.store = 1'b1;
                                id_ex_d.store_data = rt_val;
                        end
                        mips_pkg::OP_BEQ: is_beq = 1'b1;
                        mips_pkg::OP_BNE: is_bne = 1'b1;
                        default: id_ex_d = '0;
                endcase
        end

        // a branch waiting on a load must not redirect yet
        assign redirect_o = ((is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val))
                && !hold_i;
        assign target_o = if_id_i.pc + 32'd4 + {imm_sext[29:0], 2'b00};

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        id_ex_o <= '0;
                end else if (!freeze_i) begin
                        if (bubble_i) begin
                                id_ex_o <= '0;
                        end else begin
                                id_ex_o <= id_ex_d;
                        end
                end
        end
endmodule

`default_nettype wire

/* hw/exec_stage.sv */
`default_nettype none

module exec_stage (
        input wire clk,
        input wire rst_n,
        input wire freeze_i,
        input wire mips_pkg::id_ex_t id_ex_i,
        output mips_pkg::fwd_t ex_fwd_o,
        output mips_pkg::ex_mm_t ex_mm_o
);
        mips_pkg::word_t result;

        always_comb begin
                case (id_ex_i.op)
                        mips_pkg::ALU_ADD: result = id_ex_i.a + id_ex_i.b; // also lw/sw address
                        mips_pkg::ALU_SUB: result = id_ex_i.a - id_ex_i.b;
                        mips_pkg::ALU_AND: result = id_ex_i.a & id_ex_i.b;
                        mips_pkg::ALU_OR: result = id_ex_i.a | id_ex_i.b;
                        mips_pkg::ALU_SLT: result = {31'b0, $signed(id_ex_i.a) < $signed(id_ex_i.b)};
                        mips_pkg::ALU_LUI: result = {id_ex_i.b[15:0], 16'b0};
                        default: result = '0;
                endcase
        end

        // a load here only has its address, pipe_ctl stalls the consumer
        assign ex_fwd_o = '{
                wr: id_ex_i.reg_wr,
                dst: id_ex_i.dst,
                data: result,
                load: id_ex_i.load
        };

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        ex_mm_o <= '0;
                end else if (!freeze_i) begin
                        ex_mm_o <= '{
                                result: result,
                                store_data: id_ex_i.store_data,
                                dst: id_ex_i.dst,
                                reg_wr: id_ex_i.reg_wr,
                                load: id_ex_i.load,
                                store: id_ex_i.store
                        };
                end
        end
endmodule

`default_nettype wire

/* hw/fetch_stage.sv */
`default_nettype none

module fetch_stage (
        input wire clk,
        input wire rst_n,
        input wire freeze_i,
        input wire hold_i,
        input wire redirect_i,
        input wire mips_pkg::word_t target_i,
        input wire mips_pkg::word_t instr_i,
        output mips_pkg::word_t pc_o,
        output mips_pkg::if_id_t if_id_o
);
        mips_pkg::word_t pc;

        assign pc_o = pc; // rom answers in the same cycle

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        pc <= mips_pkg::RESET_PC;
                        if_id_o <= '0;
                end else if (!freeze_i && !hold_i) begin
                        // the word fetched beside a taken branch is its delay slot
                        pc <= redirect_i ? target_i : pc + 32'd4;
                        if_id_o <= '{instr: instr_i, pc: pc};
                end
        end
endmodule

`default_nettype wire

/* hw/mem_stage.sv */
`default_nettype none

module mem_stage (
        input wire clk,
        input wire rst_n,
        input wire freeze_i,
        input wire mips_pkg::ex_mm_t ex_mm_i,
        output mips_pkg::word_t dbus_addr_o,
        output mips_pkg::word_t dbus_wdata_o,
        output logic dbus_read_o,
        output logic dbus_write_o,
        input wire mips_pkg::word_t dbus_rdata_i,
        output mips_pkg::fwd_t mm_fwd_o,
        output mips_pkg::wb_t wb_o
);
        mips_pkg::word_t wb_val;

        assign dbus_addr_o = ex_mm_i.result;
        assign dbus_wdata_o = ex_mm_i.store_data;
        assign dbus_read_o = ex_mm_i.load;
        assign dbus_write_o = ex_mm_i.store;

        assign wb_val = ex_mm_i.load ? dbus_rdata_i : ex_mm_i.result;

        // read data is valid whenever the pipe moves, so it is always ready here
        assign mm_fwd_o = '{
                wr: ex_mm_i.reg_wr,
                dst: ex_mm_i.dst,
                data: wb_val,
                load: 1'b0
        };

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wb_o <= '0;
                end else if (!freeze_i) begin
                        wb_o <= '{we: ex_mm_i.reg_wr, idx: ex_mm_i.dst, data: wb_val};
                end
        end

        a_rw_excl: assert property (@(posedge clk) disable iff (!rst_n)
                !(dbus_read_o && dbus_write_o));

        // freeze is the bus stall, the request must not move under it
        a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
                freeze_i && (dbus_read_o || dbus_write_o)
                |=> $stable({dbus_addr_o, dbus_wdata_o, dbus_read_o, dbus_write_o}));
endmodule

`default_nettype wire

/* hw/mips_core.sv */
`default_nettype none

module mips_core (
        input wire clk,
        input wire rst_n,
        output wire mips_pkg::word_t ibus_addr_o,
        input wire mips_pkg::word_t ibus_rdata_i,
        output wire mips_pkg::word_t dbus_addr_o,
        output wire mips_pkg::word_t dbus_wdata_o,
        output wire dbus_read_o,
        output wire dbus_write_o,
        input wire mips_pkg::word_t dbus_rdata_i,
        input wire dbus_stall_i
);
        wire mips_pkg::if_id_t if_id;
        wire mips_pkg::id_ex_t id_ex;
        wire mips_pkg::ex_mm_t ex_mm;
        wire mips_pkg::fwd_t ex_fwd;
        wire mips_pkg::fwd_t mm_fwd;
        wire mips_pkg::wb_t wb;
        wire mips_pkg::word_t target;
        wire mips_pkg::word_t rs_data;
        wire mips_pkg::word_t rt_data;
        wire mips_pkg::reg_idx_t rs;
        wire mips_pkg::reg_idx_t rt;
        wire redirect;
        wire freeze;
        wire hold;
        wire bubble;

        fetch_stage u_fetch (
                .clk(clk),
                .rst_n(rst_n),
                .freeze_i(freeze),
                .hold_i(hold),
                .redirect_i(redirect),
                .target_i(target),
                .instr_i(ibus_rdata_i),
                .pc_o(ibus_addr_o),
                .if_id_o(if_id)
        );

        decode_stage u_decode (
                .clk(clk),
                .rst_n(rst_n),
                .freeze_i(freeze),
                .hold_i(hold),
                .bubble_i(bubble),
                .if_id_i(if_id),
                .rs_data_i(rs_data),
                .rt_data_i(rt_data),
                .rs_o(rs),
                .rt_o(rt),
                .ex_fwd_i(ex_fwd),
                .mm_fwd_i(mm_fwd),
                .wb_i(wb),
                .redirect_o(redirect),
                .target_o(target),
                .id_ex_o(id_ex)
        );

        reg_file u_regs (
                .clk(clk),
                .rst_n(rst_n),
                .rs_i(rs),
                .rt_i(rt),
                .wb_i(wb),
                .rs_data_o(rs_data),
                .rt_data_o(rt_data)
        );

        exec_stage u_exec (
                .clk(clk),
                .rst_n(rst_n),
                .freeze_i(freeze),
                .id_ex_i(id_ex),
                .ex_fwd_o(ex_fwd),
                .ex_mm_o(ex_mm)
        );

        mem_stage u_mem (
                .clk(clk),
                .rst_n(rst_n),
                .freeze_i(freeze),
                .ex_mm_i(ex_mm),
                .dbus_addr_o(dbus_addr_o),
                .dbus_wdata_o(dbus_wdata_o),
                .dbus_read_o(dbus_read_o),
                .dbus_write_o(dbus_write_o),
                .dbus_rdata_i(dbus_rdata_i),
                .mm_fwd_o(mm_fwd),
                .wb_o(wb)
        );

        pipe_ctl u_ctl (
                .dbus_stall_i(dbus_stall_i),
                .rs_i(rs),
                .rt_i(rt),
                .ex_fwd_i(ex_fwd),
                .freeze_o(freeze),
                .hold_o(hold),
                .bubble_o(bubble)
        );
endmodule

`default_nettype wire

/* hw/mips_pkg.sv */
`default_nettype none

package mips_pkg;
        localparam int XLEN = 32;
        localparam int REG_AW = 5;

        typedef logic [XLEN-1:0] word_t;
        typedef logic [REG_AW-1:0] reg_idx_t;

        localparam word_t RESET_PC = '0;

        typedef enum logic [5:0] {
                OP_SPECIAL = 6'h00,
                OP_BEQ = 6'h04,
                OP_BNE = 6'h05,
                OP_ADDIU = 6'h09,
                OP_ORI = 6'h0d,
                OP_LUI = 6'h0f,
                OP_LW = 6'h23,
                OP_SW = 6'h2b
        } opcode_e;

        typedef enum logic [5:0] {
                FN_ADDU = 6'h21,
                FN_SUBU = 6'h23,
                FN_AND = 6'h24,
                FN_OR = 6'h25,
                FN_SLT = 6'h2a
        } funct_e;

        typedef enum logic [2:0] {
                ALU_NOP = 3'd0, // must stay zero, an all-zero stage register is a nop
                ALU_ADD = 3'd1,
                ALU_SUB = 3'd2,
                ALU_AND = 3'd3,
                ALU_OR = 3'd4,
                ALU_SLT = 3'd5,
                ALU_LUI = 3'd6
        } alu_op_e;

        typedef struct packed {
                word_t instr;
                word_t pc;
        } if_id_t;

        typedef struct packed {
                alu_op_e op;
                word_t a;
                word_t b;
                reg_idx_t dst;
                logic reg_wr;
                logic load;
                logic store;
                word_t store_data;
        } id_ex_t;

        typedef struct packed {
                word_t result; // alu result or memory address
                word_t store_data;
                reg_idx_t dst;
                logic reg_wr;
                logic load;
                logic store;
        } ex_mm_t;

        typedef struct packed {
                logic wr;
                reg_idx_t dst;
                word_t data;
                logic load; // data not valid yet
        } fwd_t;

        typedef struct packed {
                logic we;
                reg_idx_t idx;
                word_t data;
        } wb_t;
endpackage

`default_nettype wire

/* hw/pipe_ctl.sv */
`default_nettype none

module pipe_ctl (
        input wire dbus_stall_i,
        input wire mips_pkg::reg_idx_t rs_i,
        input wire mips_pkg::reg_idx_t rt_i,
        input wire mips_pkg::fwd_t ex_fwd_i,
        output logic freeze_o,
        output logic hold_o,
        output logic bubble_o
);
        logic load_use;

        // load in execute feeding the instruction in decode
        assign load_use = ex_fwd_i.load && ex_fwd_i.wr && ex_fwd_i.dst != '0
                && (ex_fwd_i.dst == rs_i || ex_fwd_i.dst == rt_i);

        assign freeze_o = dbus_stall_i;
        assign hold_o = load_use && !dbus_stall_i; // freeze already holds everything
        assign bubble_o = load_use && !dbus_stall_i;
endmodule

`default_nettype wire

/* hw/reg_file.sv */
`default_nettype none

module reg_file (
        input wire clk,
        input wire rst_n,
        input wire mips_pkg::reg_idx_t rs_i,
        input wire mips_pkg::reg_idx_t rt_i,
        input wire mips_pkg::wb_t wb_i,
        output mips_pkg::word_t rs_data_o,
        output mips_pkg::word_t rt_data_o
);
        mips_pkg::word_t regs [2**mips_pkg::REG_AW];

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < 2**mips_pkg::REG_AW; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wb_i.we && wb_i.idx != '0) begin
                        regs[wb_i.idx] <= wb_i.data;
                end
        end

        // same-cycle write is seen through the writeback forward in decode
        assign rs_data_o = regs[rs_i];
        assign rt_data_o = regs[rt_i];

        a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
                (rs_i != '0 || rs_data_o == '0) && (rt_i != '0 || rt_data_o == '0));
endmodule

`default_nettype wire

/* sim.f */
+incdir+tests
hw/mips_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/exec_stage.sv
hw/mem_stage.sv
hw/pipe_ctl.sv
hw/mips_core.sv
tests/tb_mips_core.sv

/* tests/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam mips_pkg::word_t MARKER_ADDR = 32'h0000_03f0;
localparam int MODEL_STEPS = 200;
localparam int MODEL_TAIL = 10; // fetches the pipeline may run ahead of the marker store

function automatic mips_pkg::word_t ram_fill(int idx);
        return (idx * 32'h9e37_79b1) ^ 32'h5a5a_0000;
endfunction

function automatic mips_pkg::word_t r_type(mips_pkg::funct_e fn, int rd, int rs, int rt);
        return {mips_pkg::OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
endfunction

function automatic mips_pkg::word_t i_type(mips_pkg::opcode_e op, int rt, int rs, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

task automatic load_program();
        for (int i = 0; i < ROM_WORDS; i++) begin
                rom[i] = '0;
        end
        rom[0] = i_type(mips_pkg::OP_ADDIU, 1, 0, 5);
        rom[1] = i_type(mips_pkg::OP_ADDIU, 2, 1, -3); // uses r1 from execute
        rom[2] = r_type(mips_pkg::FN_ADDU, 3, 1, 2);
        rom[3] = r_type(mips_pkg::FN_SUBU, 4, 2, 3); // goes negative
        rom[4] = r_type(mips_pkg::FN_SLT, 5, 4, 1);
        rom[5] = r_type(mips_pkg::FN_AND, 6, 3, 4);
        rom[6] = r_type(mips_pkg::FN_OR, 7, 6, 5);
        rom[7] = i_type(mips_pkg::OP_LUI, 8, 0, 'h1234);
        rom[8] = i_type(mips_pkg::OP_ORI, 8, 8, 'h5678);
        rom[9] = i_type(mips_pkg::OP_SW, 4, 0, 0);
        rom[10] = i_type(mips_pkg::OP_SW, 7, 0, 4);
        rom[11] = i_type(mips_pkg::OP_SW, 8, 0, 8);
        rom[12] = i_type(mips_pkg::OP_LW, 9, 0, 64);
        rom[13] = r_type(mips_pkg::FN_ADDU, 10, 9, 5); // load-use
        rom[14] = i_type(mips_pkg::OP_SW, 10, 0, 12);
        rom[15] = i_type(mips_pkg::OP_LW, 11, 0, 8); // reads back the earlier store
        rom[16] = i_type(mips_pkg::OP_BEQ, 8, 11, 2); // taken, waits on the load
        rom[17] = i_type(mips_pkg::OP_ADDIU, 12, 0, 7); // delay slot
        rom[18] = i_type(mips_pkg::OP_SW, 0, 0, 16);
        rom[19] = i_type(mips_pkg::OP_BNE, 1, 1, 2); // not taken
        rom[20] = r_type(mips_pkg::FN_SLT, 13, 4, 12);
        rom[21] = i_type(mips_pkg::OP_BNE, 0, 13, 2); // taken
        rom[22] = r_type(mips_pkg::FN_OR, 14, 12, 13);
        rom[23] = i_type(mips_pkg::OP_SW, 0, 0, 20);
        rom[24] = i_type(mips_pkg::OP_BEQ, 2, 1, 1); // not taken
        rom[25] = i_type(mips_pkg::OP_SW, 12, 0, 16);
        rom[26] = i_type(mips_pkg::OP_SW, 14, 0, 20);
        rom[27] = i_type(mips_pkg::OP_SW, 1, 0, int'(MARKER_ADDR));
        rom[28] = i_type(mips_pkg::OP_BEQ, 0, 0, -1); // parks here
        rom[29] = 32'hffff_ffff; // undecoded opcode
endtask

// architectural run with one delay slot, no timing
task automatic run_model();
        mips_pkg::word_t regs [32];
        mips_pkg::word_t mem [RAM_WORDS];
        mips_pkg::word_t pc;
        mips_pkg::word_t npc;
        mips_pkg::word_t after;
        mips_pkg::word_t ins;
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t imm;
        mips_pkg::word_t addr;
        int tail;
        for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
                mem[i] = ram_fill(i);
        end
        pc = mips_pkg::RESET_PC;
        npc = pc + 32'd4;
        tail = -1;
        for (int step = 0; step < MODEL_STEPS && tail != 0; step++) begin
                fetch_q.push_back(pc);
                ins = rom[pc[7:2]];
                a = regs[ins[25:21]];
                b = regs[ins[20:16]];
                imm = {{16{ins[15]}}, ins[15:0]};
                addr = a + imm;
                after = npc + 32'd4;
                case (ins[31:26])
                        mips_pkg::OP_SPECIAL: case (ins[5:0])
                                mips_pkg::FN_ADDU: regs[ins[15:11]] = a + b;
                                mips_pkg::FN_SUBU: regs[ins[15:11]] = a - b;
                                mips_pkg::FN_AND: regs[ins[15:11]] = a & b;
                                mips_pkg::FN_OR: regs[ins[15:11]] = a | b;
                                mips_pkg::FN_SLT: regs[ins[15:11]] = {31'd0, $signed(a) < $signed(b)};
                                default: ;
                        endcase
                        mips_pkg::OP_ADDIU: regs[ins[20:16]] = addr;
                        mips_pkg::OP_ORI: regs[ins[20:16]] = a | {16'h0, ins[15:0]};
                        mips_pkg::OP_LUI: regs[ins[20:16]] = {ins[15:0], 16'h0};
                        mips_pkg::OP_LW: regs[ins[20:16]] = mem[addr[9:2]];
                        mips_pkg::OP_SW: begin
                                mem[addr[9:2]] = b;
                                store_q.push_back('{addr: addr, data: b});
                                if (addr == MARKER_ADDR) begin
                                        tail = MODEL_TAIL;
                                end
                        end
                        mips_pkg::OP_BEQ: if (a == b) after = pc + 32'd4 + (imm << 2);
                        mips_pkg::OP_BNE: if (a != b) after = pc + 32'd4 + (imm << 2);
                        default: ;
                endcase
                regs[0] = '0;
                if (tail > 0) begin
                        tail--;
                end
                pc = npc;
                npc = after;
        end
endtask

`endif

/* tests/tb_mips_core.sv */
`default_nettype none

module tb_mips_core;
        localparam int ROM_WORDS = 64;
        localparam int RAM_WORDS = 256;
        localparam int TIMEOUT_CYCLES = 3000;

        typedef struct packed {
                mips_pkg::word_t addr;
                mips_pkg::word_t data;
        } store_t;

        logic clk;
        logic rst_n;
        logic dbus_stall;
        mips_pkg::word_t ibus_rdata;
        mips_pkg::word_t dbus_rdata;
        wire mips_pkg::word_t ibus_addr;
        wire mips_pkg::word_t dbus_addr;
        wire mips_pkg::word_t dbus_wdata;
        wire dbus_read;
        wire dbus_write;

        mips_pkg::word_t rom [ROM_WORDS];
        mips_pkg::word_t data_ram [RAM_WORDS];
        mips_pkg::word_t fetch_q [$];
        store_t store_q [$];
        store_t exp_store;
        mips_pkg::word_t exp_pc;
        mips_pkg::word_t last_fetch;
        logic fetch_seen = 1'b0;
        logic marker_seen = 1'b0;

`include "tb_program.svh"

        mips_core DUT (
                .clk(clk),
                .rst_n(rst_n),
                .ibus_addr_o(ibus_addr),
                .ibus_rdata_i(ibus_rdata),
                .dbus_addr_o(dbus_addr),
                .dbus_wdata_o(dbus_wdata),
                .dbus_read_o(dbus_read),
                .dbus_write_o(dbus_write),
                .dbus_rdata_i(dbus_rdata),
                .dbus_stall_i(dbus_stall)
        );

        task automatic stop_run(input string why);
                $display("%s", why);
                $display("TEST FAILED");
                $fatal(1);
        endtask

        function automatic string mismatch(string name, mips_pkg::word_t exp, mips_pkg::word_t act);
                return $sformatf("FAILED %s expected %h actual %h", name, exp, act);
        endfunction

        task automatic drive_inputs();
                dbus_stall = ($urandom % 3) == 0; // about a third of cycles
                ibus_rdata = rom[ibus_addr[7:2]];
                dbus_rdata = dbus_read ? data_ram[dbus_addr[9:2]] : '0;
        endtask

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        // fetch order, repeats from held cycles collapse
        always @(posedge clk) begin
                if (rst_n && (!fetch_seen || ibus_addr != last_fetch)) begin
                        fetch_seen = 1'b1;
                        last_fetch = ibus_addr;
                        assert (fetch_q.size() > 0) else stop_run("fetch ran past the model sequence");
                        exp_pc = fetch_q.pop_front();
                        assert (ibus_addr == exp_pc) else stop_run(mismatch("ibus_addr_o", exp_pc, ibus_addr));
                end
        end

        always @(posedge clk) begin
                if (rst_n && dbus_write && !dbus_stall) begin
                        data_ram[dbus_addr[9:2]] = dbus_wdata;
                        assert (store_q.size() > 0) else stop_run("store seen after the model stores ran out");
                        exp_store = store_q.pop_front();
                        assert (dbus_addr == exp_store.addr)
                                else stop_run(mismatch("dbus_addr_o", exp_store.addr, dbus_addr));
                        assert (dbus_wdata == exp_store.data)
                                else stop_run(mismatch("dbus_wdata_o", exp_store.data, dbus_wdata));
                        if (dbus_addr == MARKER_ADDR) begin
                                assert (store_q.size() == 0) else stop_run("marker store came too early");
                                marker_seen = 1'b1;
                        end
                end
        end

        a_rw_excl: assert property (@(posedge clk) disable iff (!rst_n)
                !(dbus_read && dbus_write))
                else stop_run("dbus_read_o and dbus_write_o high together");

        a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
                dbus_stall |=> $stable({dbus_addr, dbus_wdata, dbus_read, dbus_write}))
                else stop_run("data bus request changed while dbus_stall_i was high");

        initial begin
                int cycles;
                void'($urandom(3));
                rst_n = 1'b0;
                dbus_stall = 1'b0;
                ibus_rdata = '0;
                dbus_rdata = '0;
                load_program();
                for (int i = 0; i < RAM_WORDS; i++) begin
                        data_ram[i] = ram_fill(i);
                end
                run_model();
                repeat (8) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
                assert (ibus_addr == mips_pkg::RESET_PC)
                        else stop_run(mismatch("ibus_addr_o", mips_pkg::RESET_PC, ibus_addr));
                assert (!dbus_read && !dbus_write) else stop_run("data bus request active after reset");
                drive_inputs();
                cycles = 0;
                while (!marker_seen && cycles < TIMEOUT_CYCLES) begin
                        @(negedge clk);
                        drive_inputs();
                        cycles++;
                end
                if (marker_seen) begin
                        $display("TEST OK");
                        $finish;
                end else begin
                        stop_run("timeout waiting for the marker store");
                end
        end
endmodule

`default_nettype wire
